//--- build.f
source/fdc_pkg.sv
source/fdc_result_fifo.sv
source/fdc_step_engine.sv
source/fdc_host_port.sv
source/fdc_command_seq.sv
source/fdc_top.sv
test/tb_fdc.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module tb_fdc -Mdir obj_dir -f build.f; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_fdc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$LOG"; then
	echo "no pass line found in $LOG"
	exit 1
fi
exit 0

//--- source/fdc_command_seq.sv
// command FSM; seeks to a drive that is still stepping are dropped without a reply
`timescale 1ns/10ps

module fdc_command_seq (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           i_data_wr,
	input  fdc_pkg::byte_t i_data_byte,
	input  logic           i_fifo_empty,
	input  logic           i_fifo_full,
	input  logic [1:0]     i_ready,
	input  logic [1:0]     i_motor,
	input  logic [1:0]     i_available,
	input  logic [1:0]     i_wp,
	input  logic [1:0]     i_two_sided,
	input  fdc_pkg::cyl_t  i_tracks0,
	input  fdc_pkg::cyl_t  i_tracks1,
	input  logic [1:0]     i_busy,
	input  logic [1:0]     i_int_pending,
	input  logic [1:0]     i_on_target,
	input  fdc_pkg::cyl_t  i_pcn0,
	input  fdc_pkg::cyl_t  i_pcn1,
	output logic           o_idle,
	output logic           o_push,
	output fdc_pkg::byte_t o_push_byte,
	output logic [1:0]     o_seek_start,
	output logic [1:0]     o_seek_reject,
	output logic [1:0]     o_int_clear,
	output fdc_pkg::cyl_t  o_seek_target,
	output logic [3:0]     o_srt
);
	import fdc_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_SPEC_SRT,
		S_SPEC_HLT,
		S_SDS_DRV,
		S_RECAL_DRV,
		S_SEEK_DRV,
		S_SEEK_CYL,
		S_SINT_PCN
	} state_t;

	state_t state;
	logic   drv;     // drive latched for seek and sense interrupt
	logic   dsel;    // drive bit of the incoming byte
	logic   int_drv; // drive 0 is served first
	cyl_t   pcn_drv;
	cyl_t   pcn_dsel;
	cyl_t   tracks_drv;
	logic   seek_ok;
	byte_t  st0;
	byte_t  st3;

	assign dsel       = i_data_byte[0];
	assign int_drv    = ~i_int_pending[0];
	assign pcn_drv    = drv ? i_pcn1 : i_pcn0;
	assign pcn_dsel   = dsel ? i_pcn1 : i_pcn0;
	assign tracks_drv = drv ? i_tracks1 : i_tracks0;
	assign o_idle     = (state == S_IDLE);

	// target 0 always allowed, so recalibrate works without a disk
	assign seek_ok = (i_data_byte == 8'd0) ||
		(i_motor[drv] && i_ready[drv] && (i_data_byte < tracks_drv));

	assign st0 = (i_on_target[int_drv] && i_ready[int_drv]) ?
		(ST0_SEEK_OK | {7'd0, int_drv}) : (ST0_SEEK_FAIL | {7'd0, int_drv});

	assign st3 = {1'b0,
		i_ready[dsel] & i_wp[dsel],
		i_available[dsel],
		pcn_dsel == 8'd0,                  // track 0
		i_two_sided[dsel],
		i_data_byte[2] & i_two_sided[dsel], // head
		1'b0,
		dsel};

	// ==================================================
	// sequencer
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state         <= S_IDLE;
			drv           <= 1'b0;
			o_srt         <= SRT_RESET;
			o_push        <= 1'b0;
			o_push_byte   <= '0;
			o_seek_start  <= '0;
			o_seek_reject <= '0;
			o_int_clear   <= '0;
			o_seek_target <= '0;
		end else begin
			o_push        <= 1'b0; // all pulses last one cycle
			o_seek_start  <= '0;
			o_seek_reject <= '0;
			o_int_clear   <= '0;
			case (state)
				S_IDLE: begin
					if (i_data_wr && i_fifo_empty) begin
						case (i_data_byte)
							OPC_SPECIFY: begin
								o_int_clear <= 2'b11;
								state       <= S_SPEC_SRT;
							end
							OPC_SENSE_DRIVE: begin
								o_int_clear <= 2'b11;
								state       <= S_SDS_DRV;
							end
							OPC_RECALIBRATE: state <= S_RECAL_DRV;
							OPC_SEEK:        state <= S_SEEK_DRV;
							OPC_SENSE_INT: begin
								o_push <= 1'b1;
								if (|i_int_pending) begin
									o_push_byte <= st0;
									drv         <= int_drv;
									state       <= S_SINT_PCN;
								end else begin
									o_push_byte <= ST0_INVALID;
								end
							end
							default: begin // data commands land here too
								o_int_clear <= 2'b11;
								o_push      <= 1'b1;
								o_push_byte <= ST0_INVALID;
							end
						endcase
					end
				end
				S_SPEC_SRT: if (i_data_wr) begin
					o_srt <= i_data_byte[7:4]; // head unload time ignored
					state <= S_SPEC_HLT;
				end
				S_SPEC_HLT: if (i_data_wr) state <= S_IDLE;
				S_SDS_DRV: if (i_data_wr) begin
					o_push      <= 1'b1;
					o_push_byte <= st3;
					state       <= S_IDLE;
				end
				S_RECAL_DRV: if (i_data_wr) begin
					o_int_clear[dsel] <= 1'b1;
					o_seek_target     <= '0;
					if (!i_busy[dsel])
						o_seek_start[dsel] <= 1'b1;
					state <= S_IDLE;
				end
				S_SEEK_DRV: if (i_data_wr) begin
					drv               <= dsel;
					o_int_clear[dsel] <= 1'b1;
					state             <= S_SEEK_CYL;
				end
				S_SEEK_CYL: if (i_data_wr) begin
					o_seek_target <= i_data_byte;
					if (!i_busy[drv]) begin
						if (seek_ok)
							o_seek_start[drv] <= 1'b1;
						else
							o_seek_reject[drv] <= 1'b1;
					end
					state <= S_IDLE;
				end
				S_SINT_PCN: begin // second result byte, then drop the interrupt
					o_push           <= 1'b1;
					o_push_byte      <= pcn_drv;
					o_int_clear[drv] <= 1'b1;
					state            <= S_IDLE;
				end
			endcase
		end
	end

	assert property (@(posedge clk_sys) disable iff (reset) o_push |-> !i_fifo_full)
		else $error("result push into a full buffer");

endmodule

//--- source/fdc_host_port.sv
// host bus side; strobes are sampled on clk_sys and must be held low for at least two cycles
`timescale 1ns/10ps

module fdc_host_port (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           i_a0,
	input  logic           i_nrd,
	input  logic           i_nwr,
	input  fdc_pkg::byte_t i_din,
	input  logic           i_fifo_empty,
	input  fdc_pkg::byte_t i_fifo_head,
	input  logic           i_idle,
	input  logic [1:0]     i_busy,
	output fdc_pkg::byte_t o_dout,
	output logic           o_data_wr,
	output fdc_pkg::byte_t o_data_byte,
	output logic           o_data_rd
);
	import fdc_pkg::*;

	logic  rd_lvl;
	logic  wr_lvl;
	logic  rd_q;
	logic  rd_q2;
	logic  wr_q;
	logic  wr_q2;
	logic  a0_q;
	byte_t din_q;
	logic  rd_edge;
	byte_t msr;

	assign rd_lvl = i_nwr & ~i_nrd;
	assign wr_lvl = ~i_nwr & i_nrd;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_q  <= 1'b0;
			rd_q2 <= 1'b0;
			wr_q  <= 1'b0;
			wr_q2 <= 1'b0;
		end else begin
			rd_q  <= rd_lvl;
			rd_q2 <= rd_q;
			wr_q  <= wr_lvl;
			wr_q2 <= wr_q;
		end
	end

	// address and data sampled alongside the strobes
	always_ff @(posedge clk_sys) begin
		a0_q  <= i_a0;
		din_q <= i_din;
	end

	assign rd_edge     = rd_q & ~rd_q2;
	assign o_data_rd   = rd_edge & a0_q & ~i_fifo_empty; // pops only when a byte is there
	assign o_data_wr   = wr_q & ~wr_q2 & a0_q;
	assign o_data_byte = din_q;

	// ==================================================
	// main status register
	// ==================================================
	always_comb begin
		msr          = '0;
		msr[MSR_D0B] = i_busy[0];
		msr[MSR_D1B] = i_busy[1];
		msr[MSR_CB]  = ~i_idle | ~i_fifo_empty;
		msr[MSR_DIO] = ~i_fifo_empty;
		msr[MSR_RQM] = i_idle | ~i_fifo_empty;
	end

	// head is captured before the pop in the same cycle takes effect
	always_ff @(posedge clk_sys) begin
		if (rd_edge) begin
			if (!a0_q)
				o_dout <= msr;
			else if (i_fifo_empty)
				o_dout <= 8'hFF; // nothing to return
			else
				o_dout <= i_fifo_head;
		end
	end

	assert property (@(posedge clk_sys) disable iff (reset) !(o_data_rd && o_data_wr))
		else $error("host read and write pulse in the same cycle");

endmodule

//--- source/fdc_pkg.sv
// shared fdc definitions; STEP_TICKS assumes a 4 MHz clk_sys, RESULT_DEPTH must be a power of two
package fdc_pkg;

	// ==================================================
	// data types
	// ==================================================
	typedef logic [7:0] byte_t;
	typedef logic [7:0] cyl_t;

	// ==================================================
	// main status register bit positions
	// ==================================================
	localparam logic [2:0] MSR_D0B = 3'd0; // drive 0 seeking
	localparam logic [2:0] MSR_D1B = 3'd1; // drive 1 seeking
	localparam logic [2:0] MSR_CB  = 3'd4; // command busy
	localparam logic [2:0] MSR_DIO = 3'd6; // data toward host
	localparam logic [2:0] MSR_RQM = 3'd7; // request for master

	// ==================================================
	// opcodes, upper three bits must be zero
	// ==================================================
	localparam byte_t OPC_SPECIFY     = 8'h03;
	localparam byte_t OPC_SENSE_DRIVE = 8'h04;
	localparam byte_t OPC_RECALIBRATE = 8'h07;
	localparam byte_t OPC_SENSE_INT   = 8'h08;
	localparam byte_t OPC_SEEK        = 8'h0F;

	// st0 bases, drive number goes into bit 0 of the seek ones
	localparam byte_t ST0_SEEK_OK   = 8'h20;
	localparam byte_t ST0_SEEK_FAIL = 8'hE8;
	localparam byte_t ST0_INVALID   = 8'h80; // also the "no interrupt" reply

	// ==================================================
	// step timing
	// ==================================================
	// clocks per step-rate unit, 1 ms at 4 MHz
	localparam logic [19:0] STEP_TICKS = 20'd4000;

	// step rate after reset
	localparam logic [3:0] SRT_RESET = 4'd4;

	// ==================================================
	// result buffer
	// ==================================================
	localparam int RESULT_DEPTH = 4;
	localparam int RESULT_PTR_W = 2; // log2 of RESULT_DEPTH

endpackage

//--- source/fdc_result_fifo.sv
// first-word-fall-through result buffer; pushes when full and pops when empty are ignored
`timescale 1ns/10ps

module fdc_result_fifo (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           i_push,
	input  fdc_pkg::byte_t i_push_byte,
	input  logic           i_pop,
	output fdc_pkg::byte_t o_head,
	output logic           o_empty,
	output logic           o_full
);
	import fdc_pkg::*;

	byte_t                   mem [RESULT_DEPTH];
	logic [RESULT_PTR_W-1:0] wr_ptr;
	logic [RESULT_PTR_W-1:0] rd_ptr;
	logic [RESULT_PTR_W:0]   count;
	logic                    do_push;
	logic                    do_pop;

	assign o_empty = (count == '0);
	assign o_full  = (count == (RESULT_PTR_W + 1)'(RESULT_DEPTH));
	assign do_push = i_push & ~o_full;
	assign do_pop  = i_pop & ~o_empty;
	assign o_head  = mem[rd_ptr];

	always_ff @(posedge clk_sys) begin
		if (do_push)
			mem[wr_ptr] <= i_push_byte;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at the power-of-two depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// the consumer pops only a buffer that holds data
	assert property (@(posedge clk_sys) disable iff (reset) i_pop |-> !o_empty)
		else $error("result buffer popped while empty");

endmodule

//--- source/fdc_step_engine.sv
// one drive's head stepper; srt is sampled at each step, target is taken on start or reject
`timescale 1ns/10ps

module fdc_step_engine (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          i_start,
	input  logic          i_reject,
	input  logic          i_int_clear,
	input  fdc_pkg::cyl_t i_target,
	input  logic [3:0]    i_srt,
	output logic          o_busy,
	output fdc_pkg::cyl_t o_pcn,
	output logic          o_on_target,
	output logic          o_int_pending
);
	import fdc_pkg::*;

	cyl_t        ncn;      // new cylinder
	logic [19:0] tick_cnt;
	logic [4:0]  unit_cnt;
	logic [4:0]  step_units;
	logic        waiting;  // settling after a step

	// srt 0 gives the full 16 units
	assign step_units  = 5'd16 - {1'b0, i_srt};
	assign o_on_target = (o_pcn == ncn);

	// ==================================================
	// cylinder tracking and step timer
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			o_busy        <= 1'b0;
			o_pcn         <= '0;
			o_int_pending <= 1'b0;
			ncn           <= '0;
			waiting       <= 1'b0;
			tick_cnt      <= '0;
			unit_cnt      <= '0;
		end else begin
			if (i_int_clear)
				o_int_pending <= 1'b0; // a set below wins
			if (i_start) begin
				ncn     <= i_target;
				o_busy  <= 1'b1;
				waiting <= 1'b0;
			end else if (i_reject) begin
				ncn           <= i_target; // head stays put
				o_int_pending <= 1'b1;
			end else if (o_busy && waiting) begin
				if (tick_cnt != 20'd0) begin
					tick_cnt <= tick_cnt - 20'd1;
				end else if (unit_cnt != 5'd0) begin
					unit_cnt <= unit_cnt - 5'd1;
					tick_cnt <= STEP_TICKS - 20'd1;
				end else begin
					waiting <= 1'b0;
				end
			end else if (o_busy) begin
				if (o_pcn == ncn) begin
					o_busy        <= 1'b0; // arrived
					o_int_pending <= 1'b1;
				end else begin
					if (o_pcn < ncn)
						o_pcn <= o_pcn + 8'd1;
					else
						o_pcn <= o_pcn - 8'd1;
					tick_cnt <= STEP_TICKS - 20'd1;
					unit_cnt <= step_units - 5'd1;
					waiting  <= 1'b1;
				end
			end
		end
	end

	// ==================================================
	// checks
	// ==================================================
	assert property (@(posedge clk_sys) disable iff (reset)
		(o_pcn == $past(o_pcn)) || (o_pcn == $past(o_pcn) + 8'd1) ||
		(o_pcn == $past(o_pcn) - 8'd1))
		else $error("present cylinder jumped by more than one");

	// sequencer must hold back seeks to a stepping drive
	assert property (@(posedge clk_sys) disable iff (reset) !(i_start && o_busy))
		else $error("seek start while the drive is busy");

endmodule

//--- source/fdc_top.sv
// fdc command core for two drives; no data commands, image readiness folded into i_ready
`timescale 1ns/10ps

module fdc_top (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           i_a0,
	input  logic           i_nrd,
	input  logic           i_nwr,
	input  fdc_pkg::byte_t i_din,
	output fdc_pkg::byte_t o_dout,
	input  logic [1:0]     i_ready,
	input  logic [1:0]     i_motor,
	input  logic [1:0]     i_available,
	input  logic [1:0]     i_wp,
	input  logic [1:0]     i_two_sided,
	input  fdc_pkg::cyl_t  i_tracks0,
	input  fdc_pkg::cyl_t  i_tracks1
);
	import fdc_pkg::*;

	logic       data_wr;
	logic       data_rd;
	byte_t      data_byte;
	logic       fifo_empty;
	logic       fifo_full;
	byte_t      fifo_head;
	logic       idle;
	logic       push;
	byte_t      push_byte;
	logic [1:0] seek_start;
	logic [1:0] seek_reject;
	logic [1:0] int_clear;
	cyl_t       seek_target;
	logic [3:0] srt;
	logic [1:0] busy;
	logic [1:0] int_pending;
	logic [1:0] on_target;
	cyl_t       pcn0;
	cyl_t       pcn1;

	// ==================================================
	// host side
	// ==================================================
	fdc_host_port u_host (
		.clk_sys(clk_sys), .reset(reset),
		.i_a0(i_a0), .i_nrd(i_nrd), .i_nwr(i_nwr), .i_din(i_din),
		.i_fifo_empty(fifo_empty), .i_fifo_head(fifo_head),
		.i_idle(idle), .i_busy(busy),
		.o_dout(o_dout), .o_data_wr(data_wr), .o_data_byte(data_byte), .o_data_rd(data_rd)
	);

	fdc_result_fifo u_fifo (
		.clk_sys(clk_sys), .reset(reset),
		.i_push(push), .i_push_byte(push_byte), .i_pop(data_rd),
		.o_head(fifo_head), .o_empty(fifo_empty), .o_full(fifo_full)
	);

	fdc_command_seq u_cmd (
		.clk_sys(clk_sys), .reset(reset),
		.i_data_wr(data_wr), .i_data_byte(data_byte),
		.i_fifo_empty(fifo_empty), .i_fifo_full(fifo_full),
		.i_ready(i_ready), .i_motor(i_motor), .i_available(i_available),
		.i_wp(i_wp), .i_two_sided(i_two_sided),
		.i_tracks0(i_tracks0), .i_tracks1(i_tracks1),
		.i_busy(busy), .i_int_pending(int_pending), .i_on_target(on_target),
		.i_pcn0(pcn0), .i_pcn1(pcn1),
		.o_idle(idle), .o_push(push), .o_push_byte(push_byte),
		.o_seek_start(seek_start), .o_seek_reject(seek_reject), .o_int_clear(int_clear),
		.o_seek_target(seek_target), .o_srt(srt)
	);

	// ==================================================
	// one step engine per drive
	// ==================================================
	fdc_step_engine u_step0 (
		.clk_sys(clk_sys), .reset(reset),
		.i_start(seek_start[0]), .i_reject(seek_reject[0]), .i_int_clear(int_clear[0]),
		.i_target(seek_target), .i_srt(srt),
		.o_busy(busy[0]), .o_pcn(pcn0), .o_on_target(on_target[0]), .o_int_pending(int_pending[0])
	);

	fdc_step_engine u_step1 (
		.clk_sys(clk_sys), .reset(reset),
		.i_start(seek_start[1]), .i_reject(seek_reject[1]), .i_int_clear(int_clear[1]),
		.i_target(seek_target), .i_srt(srt),
		.o_busy(busy[1]), .o_pcn(pcn1), .o_on_target(on_target[1]), .o_int_pending(int_pending[1])
	);

endmodule

//--- test/tb_fdc.sv
// table-driven testbench for fdc_top; seeks run at the real STEP_TICKS rate, so long cases take many cycles
`timescale 1ns/10ps

module tb_fdc;
	import fdc_pkg::*;

	localparam int N_CASES    = 18;
	localparam int MAX_CYCLES = N_CASES * (2 + 40 * 16 * int'(STEP_TICKS));

	logic       clk_sys;
	logic       reset;
	logic       i_a0;
	logic       i_nrd;
	logic       i_nwr;
	byte_t      i_din;
	byte_t      o_dout;
	logic [1:0] i_ready;
	logic [1:0] i_motor;
	logic [1:0] i_available;
	logic [1:0] i_wp;
	logic [1:0] i_two_sided;
	cyl_t       i_tracks0;
	cyl_t       i_tracks1;

	// ==================================================
	// case table, one entry per index
	// ==================================================
	string            case_name [N_CASES];
	logic [1:0]       t_ready   [N_CASES];
	logic [1:0]       t_motor   [N_CASES];
	logic [1:0]       t_avail   [N_CASES];
	logic [1:0]       t_wp      [N_CASES];
	logic [1:0]       t_two     [N_CASES];
	cyl_t             t_trk0    [N_CASES];
	cyl_t             t_trk1    [N_CASES];
	int               t_ncmd    [N_CASES];
	logic [0:2][7:0]  t_cmd     [N_CASES]; // opcode first
	logic             t_poll    [N_CASES]; // wait for seeks to finish
	byte_t            t_msr     [N_CASES]; // status right after the command
	int               t_nres    [N_CASES];
	logic [0:1][7:0]  t_res     [N_CASES];

	int n_cases;
	int errors;
	int checks;
	int cycles;
	int k;

	fdc_top u_dut (
		.clk_sys(clk_sys), .reset(reset),
		.i_a0(i_a0), .i_nrd(i_nrd), .i_nwr(i_nwr), .i_din(i_din), .o_dout(o_dout),
		.i_ready(i_ready), .i_motor(i_motor), .i_available(i_available),
		.i_wp(i_wp), .i_two_sided(i_two_sided),
		.i_tracks0(i_tracks0), .i_tracks1(i_tracks1)
	);

	always #5 clk_sys = ~clk_sys;

	// run limit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic add_case(input string name, input logic [1:0] ready, input logic [1:0] motor,
		input logic [1:0] avail, input logic [1:0] wp, input logic [1:0] two,
		input cyl_t trk0, input cyl_t trk1, input int ncmd, input logic [0:2][7:0] cmd,
		input logic poll, input byte_t msr, input int nres, input logic [0:1][7:0] res);
		case_name[n_cases] = name;
		t_ready[n_cases]   = ready;
		t_motor[n_cases]   = motor;
		t_avail[n_cases]   = avail;
		t_wp[n_cases]      = wp;
		t_two[n_cases]     = two;
		t_trk0[n_cases]    = trk0;
		t_trk1[n_cases]    = trk1;
		t_ncmd[n_cases]    = ncmd;
		t_cmd[n_cases]     = cmd;
		t_poll[n_cases]    = poll;
		t_msr[n_cases]     = msr;
		t_nres[n_cases]    = nres;
		t_res[n_cases]     = res;
		n_cases++;
	endtask

	// drive 0 ends the seek rows at cylinder 5, drive 1 back at 0
	task automatic load_cases();
		add_case("after_reset", 2'b11, 2'b11, 2'b11, 2'b00, 2'b11, 8'd40, 8'd40,
			0, {8'h00, 8'h00, 8'h00}, 1'b0, 8'h80, 0, {8'h00, 8'h00});
		add_case("invalid_06", 2'b11, 2'b11, 2'b11, 2'b00, 2'b11, 8'd40, 8'd40,
			1, {8'h06, 8'h00, 8'h00}, 1'b0, 8'hD0, 1, {8'h80, 8'h00});
		add_case("specify_srt15", 2'b11, 2'b11, 2'b11, 2'b00, 2'b11, 8'd40, 8'd40,
			3, {OPC_SPECIFY, 8'hF0, 8'h02}, 1'b0, 8'h80, 0, {8'h00, 8'h00});
		add_case("seek_d0_c5", 2'b11, 2'b11, 2'b11, 2'b00, 2'b11, 8'd40, 8'd40,
			3, {OPC_SEEK, 8'h00, 8'h05}, 1'b1, 8'h81, 0, {8'h00, 8'h00});
		add_case("sense_int_d0", 2'b11, 2'b11, 2'b11, 2'b00, 2'b11, 8'd40, 8'd40,
			1, {OPC_SENSE_INT, 8'h00, 8'h00}, 1'b0, 8'hD0, 2, {8'h20, 8'h05});
		add_case("sense_int_none", 2'b11, 2'b11, 2'b11, 2'b00, 2'b11, 8'd40, 8'd40,
			1, {OPC_SENSE_INT, 8'h00, 8'h00}, 1'b0, 8'hD0, 1, {8'h80, 8'h00});
		add_case("seek_reject_tracks", 2'b11, 2'b11, 2'b11, 2'b00, 2'b11, 8'd40, 8'd40,
			3, {OPC_SEEK, 8'h00, 8'd40}, 1'b0, 8'h80, 0, {8'h00, 8'h00});
		add_case("sense_int_reject0", 2'b11, 2'b11, 2'b11, 2'b00, 2'b11, 8'd40, 8'd40,
			1, {OPC_SENSE_INT, 8'h00, 8'h00}, 1'b0, 8'hD0, 2, {8'hE8, 8'h05});
		add_case("seek_reject_motor", 2'b11, 2'b01, 2'b11, 2'b00, 2'b11, 8'd40, 8'd40,
			3, {OPC_SEEK, 8'h01, 8'h03}, 1'b0, 8'h80, 0, {8'h00, 8'h00});
		add_case("sense_int_reject1", 2'b11, 2'b01, 2'b11, 2'b00, 2'b11, 8'd40, 8'd40,
			1, {OPC_SENSE_INT, 8'h00, 8'h00}, 1'b0, 8'hD0, 2, {8'hE9, 8'h00});
		add_case("seek_d1_c3", 2'b11, 2'b11, 2'b11, 2'b00, 2'b11, 8'd40, 8'd40,
			3, {OPC_SEEK, 8'h01, 8'h03}, 1'b1, 8'h82, 0, {8'h00, 8'h00});
		add_case("recal_d1", 2'b11, 2'b11, 2'b11, 2'b00, 2'b11, 8'd40, 8'd40,
			2, {OPC_RECALIBRATE, 8'h01, 8'h00}, 1'b1, 8'h82, 0, {8'h00, 8'h00});
		add_case("sense_int_recal1", 2'b11, 2'b11, 2'b11, 2'b00, 2'b11, 8'd40, 8'd40,
			1, {OPC_SENSE_INT, 8'h00, 8'h00}, 1'b0, 8'hD0, 2, {8'h21, 8'h00});
		// st3 rows, values worked out bit by bit
		add_case("sds_d0_base", 2'b11, 2'b11, 2'b11, 2'b00, 2'b11, 8'd40, 8'd40,
			2, {OPC_SENSE_DRIVE, 8'h00, 8'h00}, 1'b0, 8'hD0, 1, {8'h28, 8'h00});
		add_case("sds_d1_wp_head", 2'b11, 2'b11, 2'b11, 2'b10, 2'b11, 8'd40, 8'd40,
			2, {OPC_SENSE_DRIVE, 8'h05, 8'h00}, 1'b0, 8'hD0, 1, {8'h7D, 8'h00});
		add_case("sds_d1_not_ready", 2'b01, 2'b11, 2'b11, 2'b11, 2'b11, 8'd40, 8'd40,
			2, {OPC_SENSE_DRIVE, 8'h01, 8'h00}, 1'b0, 8'hD0, 1, {8'h39, 8'h00});
		add_case("sds_d0_single_side", 2'b11, 2'b11, 2'b01, 2'b01, 2'b10, 8'd40, 8'd40,
			2, {OPC_SENSE_DRIVE, 8'h04, 8'h00}, 1'b0, 8'hD0, 1, {8'h60, 8'h00});
		add_case("sds_d1_unavailable", 2'b11, 2'b11, 2'b01, 2'b00, 2'b10, 8'd40, 8'd40,
			2, {OPC_SENSE_DRIVE, 8'h05, 8'h00}, 1'b0, 8'hD0, 1, {8'h1D, 8'h00});
	endtask

	// ==================================================
	// host bus model
	// ==================================================
	task automatic host_write(input logic a0, input byte_t data);
		@(negedge clk_sys);
		i_a0  = a0;
		i_din = data;
		i_nwr = 1'b0;
		repeat (3) @(negedge clk_sys);
		i_nwr = 1'b1;
		repeat (2) @(negedge clk_sys); // let the result pushes land
	endtask

	task automatic host_read(input logic a0, output byte_t data);
		@(negedge clk_sys);
		i_a0  = a0;
		i_nrd = 1'b0;
		repeat (3) @(negedge clk_sys);
		i_nrd = 1'b1;
		data  = o_dout; // registered two cycles ago
		@(negedge clk_sys);
	endtask

	task automatic check_byte(input string name, input string what, input byte_t exp,
		input byte_t got);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("ERR %s %s expected %02h actual %02h", name, what, exp, got);
		end
	endtask

	task automatic run_case(input int idx);
		byte_t got;
		int    i;
		@(negedge clk_sys);
		i_ready     = t_ready[idx];
		i_motor     = t_motor[idx];
		i_available = t_avail[idx];
		i_wp        = t_wp[idx];
		i_two_sided = t_two[idx];
		i_tracks0   = t_trk0[idx];
		i_tracks1   = t_trk1[idx];
		for (i = 0; i < t_ncmd[idx]; i++)
			host_write(1'b1, t_cmd[idx][i]);
		host_read(1'b0, got);
		check_byte(case_name[idx], "status after command", t_msr[idx], got);
		if (t_poll[idx]) begin
			while (got[MSR_D0B] || got[MSR_D1B])
				host_read(1'b0, got);
		end
		for (i = 0; i < t_nres[idx]; i++) begin
			host_read(1'b1, got);
			check_byte(case_name[idx], "result byte", t_res[idx][i], got);
		end
		host_read(1'b0, got);
		check_byte(case_name[idx], "status at end", 8'h80, got);
		host_read(1'b1, got);
		check_byte(case_name[idx], "read of empty buffer", 8'hFF, got);
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		clk_sys     = 1'b0;
		reset       = 1'b1;
		i_a0        = 1'b0;
		i_nrd       = 1'b1;
		i_nwr       = 1'b1;
		i_din       = '0;
		i_ready     = '0;
		i_motor     = '0;
		i_available = '0;
		i_wp        = '0;
		i_two_sided = '0;
		i_tracks0   = '0;
		i_tracks1   = '0;
		n_cases     = 0;
		errors      = 0;
		checks      = 0;
		cycles      = 0;
		load_cases();
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		for (k = 0; k < n_cases; k++)
			run_case(k);
		$display("errors: %0d of %0d checks", errors, checks);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
